/* rtl/mempool_group_pkg.sv */
// Shared TCDM widths, address map and encodings of the remote group path.
// Imported by the crossbar, the spill register and the group top level.
`default_nettype none

package mempool_group_pkg;

  // Request word format
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Byte offset inside one tile, 1 KiB each
  localparam int unsigned TileOffsetBits = 10;

  typedef logic [AddrWidth-1:0] tcdm_addr_t;
  typedef logic [DataWidth-1:0] tcdm_data_t;
  typedef logic [StrbWidth-1:0] tcdm_strb_t;

  // Request opcode
  typedef enum logic {
    TCDM_READ  = 1'b0,
    TCDM_WRITE = 1'b1
  } tcdm_op_e;

  // Occupancy of a two-entry spill register
  typedef enum logic [1:0] {
    SPILL_EMPTY = 2'd0,
    SPILL_ONE   = 2'd1,
    SPILL_TWO   = 2'd2
  } spill_fill_e;

endpackage : mempool_group_pkg

`default_nettype wire

/* rtl/tcdm_spill_register.sv */
// Two-entry valid/ready pipeline register cutting both data and ready paths.
// Ready toward the source comes from the fill state only.
`default_nettype none

module tcdm_spill_register #(
  parameter int unsigned Width = 32
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Source side
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  // Sink side
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);
  import mempool_group_pkg::*;

  spill_fill_e      fill_q;
  logic [Width-1:0] head_q;
  logic [Width-1:0] tail_q;
  logic             push;
  logic             pop;

  assign ready_o = (fill_q != SPILL_TWO);
  assign valid_o = (fill_q != SPILL_EMPTY);
  assign data_o  = head_q;

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fill_q <= SPILL_EMPTY;
    end else if (push && !pop) begin
      fill_q <= (fill_q == SPILL_EMPTY) ? SPILL_ONE : SPILL_TWO;
    end else if (pop && !push) begin
      fill_q <= (fill_q == SPILL_TWO) ? SPILL_ONE : SPILL_EMPTY;
    end
  end

  // Head is always the oldest entry
  always_ff @(posedge clk_i) begin
    if (pop) begin
      if (fill_q == SPILL_TWO) begin
        head_q <= tail_q;
      end else if (push) begin
        head_q <= data_i;
      end
    end else if (push) begin
      if (fill_q == SPILL_EMPTY) begin
        head_q <= data_i;
      end else begin
        tail_q <= data_i;
      end
    end
  end

endmodule : tcdm_spill_register

`default_nettype wire

/* rtl/tcdm_rr_arbiter.sv */
// Round-robin arbiter with a combinational one-hot grant.
// The priority pointer moves past the winner when its grant is taken.
`default_nettype none

module tcdm_rr_arbiter #(
  parameter int unsigned NumReq = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [NumReq-1:0] req_i,
  output logic [NumReq-1:0] gnt_o,
  input  logic              gnt_accept_i
);

  localparam int unsigned IdxWidth = $clog2(NumReq);

  logic [IdxWidth-1:0] prio_q;
  logic [IdxWidth-1:0] scan_idx;
  logic [IdxWidth-1:0] win_idx;
  logic                win_found;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    gnt_o     = '0;
    win_idx   = '0;
    win_found = 1'b0;
    scan_idx  = prio_q;
    for (int k = 0; k < NumReq; k++) begin
      scan_idx = prio_q + IdxWidth'(k);
      if (!win_found && req_i[scan_idx]) begin
        win_found = 1'b1;
        win_idx   = scan_idx;
      end
    end
    if (win_found) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q <= '0;
    end else if (gnt_accept_i && win_found) begin
      prio_q <= win_idx + 1'b1;
    end
  end

endmodule : tcdm_rr_arbiter

`default_nettype wire

/* rtl/tcdm_remote_xbar.sv */
// Remote TCDM crossbar between initiator ports and target tiles.
// Requests are routed by tile address bits, responses by the returned ini index.
`default_nettype none

module tcdm_remote_xbar #(
  parameter int unsigned NumTiles = 4
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  // Initiator requests
  input  logic                   [NumTiles-1:0]                    req_valid_i,
  input  mempool_group_pkg::tcdm_addr_t [NumTiles-1:0]             req_addr_i,
  input  mempool_group_pkg::tcdm_op_e   [NumTiles-1:0]             req_op_i,
  input  mempool_group_pkg::tcdm_data_t [NumTiles-1:0]             req_wdata_i,
  input  mempool_group_pkg::tcdm_strb_t [NumTiles-1:0]             req_be_i,
  output logic                   [NumTiles-1:0]                    req_ready_o,
  // Initiator responses
  output logic                   [NumTiles-1:0]                    resp_valid_o,
  output mempool_group_pkg::tcdm_data_t [NumTiles-1:0]             resp_rdata_o,
  input  logic                   [NumTiles-1:0]                    resp_ready_i,
  // Target requests
  output logic                   [NumTiles-1:0]                    tgt_req_valid_o,
  output logic [NumTiles-1:0][mempool_group_pkg::TileOffsetBits-1:0] tgt_req_addr_o,
  output logic [NumTiles-1:0][$clog2(NumTiles)-1:0]                tgt_req_ini_o,
  output mempool_group_pkg::tcdm_op_e   [NumTiles-1:0]             tgt_req_op_o,
  output mempool_group_pkg::tcdm_data_t [NumTiles-1:0]             tgt_req_wdata_o,
  output mempool_group_pkg::tcdm_strb_t [NumTiles-1:0]             tgt_req_be_o,
  input  logic                   [NumTiles-1:0]                    tgt_req_ready_i,
  // Target responses
  input  logic                   [NumTiles-1:0]                    tgt_resp_valid_i,
  input  logic [NumTiles-1:0][$clog2(NumTiles)-1:0]                tgt_resp_ini_i,
  input  mempool_group_pkg::tcdm_data_t [NumTiles-1:0]             tgt_resp_rdata_i,
  output logic                   [NumTiles-1:0]                    tgt_resp_ready_o
);
  import mempool_group_pkg::*;

  localparam int unsigned IdxWidth = $clog2(NumTiles);
  localparam int unsigned ReqWidth = TileOffsetBits + IdxWidth + 1 + DataWidth + StrbWidth;

  logic [NumTiles-1:0][IdxWidth-1:0] req_tgt;
  logic [NumTiles-1:0][ReqWidth-1:0] req_payload;
  // Indexed [target][initiator]
  logic [NumTiles-1:0][NumTiles-1:0] req_match;
  logic [NumTiles-1:0][NumTiles-1:0] req_gnt;
  logic [NumTiles-1:0]               req_spill_ready;
  // Indexed [initiator][target]
  logic [NumTiles-1:0][NumTiles-1:0] resp_match;
  logic [NumTiles-1:0][NumTiles-1:0] resp_gnt;
  logic [NumTiles-1:0]               resp_spill_ready;

  for (genvar i = 0; i < NumTiles; i++) begin : gen_ini_req
    assign req_tgt[i] = req_addr_i[i][TileOffsetBits +: IdxWidth];
    assign req_payload[i] = {req_addr_i[i][TileOffsetBits-1:0], IdxWidth'(i),
                             req_op_i[i], req_wdata_i[i], req_be_i[i]};
    // Taken when granted and the target register has room
    assign req_ready_o[i] = req_gnt[req_tgt[i]][i] & req_spill_ready[req_tgt[i]];
  end

  for (genvar t = 0; t < NumTiles; t++) begin : gen_tgt_req
    logic                req_any;
    logic                req_push;
    logic [ReqWidth-1:0] req_win;
    logic [ReqWidth-1:0] req_out;
    logic                op_bit;

    for (genvar i = 0; i < NumTiles; i++) begin : gen_match
      assign req_match[t][i] = req_valid_i[i] && (req_tgt[i] == IdxWidth'(t));
    end

    assign req_any  = |req_match[t];
    assign req_push = req_any & req_spill_ready[t];

    tcdm_rr_arbiter #(
      .NumReq(NumTiles)
    ) i_req_arb (
      .clk_i       (clk_i       ),
      .rst_n_i     (rst_n_i     ),
      .req_i       (req_match[t]),
      .gnt_o       (req_gnt[t]  ),
      .gnt_accept_i(req_push    )
    );

    always_comb begin
      req_win = '0;
      for (int i = 0; i < NumTiles; i++) begin
        if (req_gnt[t][i]) begin
          req_win = req_payload[i];
        end
      end
    end

    tcdm_spill_register #(
      .Width(ReqWidth)
    ) i_req_spill (
      .clk_i  (clk_i             ),
      .rst_n_i(rst_n_i           ),
      .valid_i(req_any           ),
      .ready_o(req_spill_ready[t]),
      .data_i (req_win           ),
      .valid_o(tgt_req_valid_o[t]),
      .ready_i(tgt_req_ready_i[t]),
      .data_o (req_out           )
    );

    assign {tgt_req_addr_o[t], tgt_req_ini_o[t], op_bit,
            tgt_req_wdata_o[t], tgt_req_be_o[t]} = req_out;
    assign tgt_req_op_o[t] = tcdm_op_e'(op_bit);

    // Response steering back to the tagged initiator
    for (genvar i = 0; i < NumTiles; i++) begin : gen_resp_match
      assign resp_match[i][t] = tgt_resp_valid_i[t] && (tgt_resp_ini_i[t] == IdxWidth'(i));
    end
    assign tgt_resp_ready_o[t] = resp_gnt[tgt_resp_ini_i[t]][t]
                               & resp_spill_ready[tgt_resp_ini_i[t]];
  end

  for (genvar i = 0; i < NumTiles; i++) begin : gen_ini_resp
    logic       resp_any;
    logic       resp_push;
    tcdm_data_t resp_win;

    assign resp_any  = |resp_match[i];
    assign resp_push = resp_any & resp_spill_ready[i];

    tcdm_rr_arbiter #(
      .NumReq(NumTiles)
    ) i_resp_arb (
      .clk_i       (clk_i        ),
      .rst_n_i     (rst_n_i      ),
      .req_i       (resp_match[i]),
      .gnt_o       (resp_gnt[i]  ),
      .gnt_accept_i(resp_push    )
    );

    always_comb begin
      resp_win = '0;
      for (int t = 0; t < NumTiles; t++) begin
        if (resp_gnt[i][t]) begin
          resp_win = tgt_resp_rdata_i[t];
        end
      end
    end

    tcdm_spill_register #(
      .Width(DataWidth)
    ) i_resp_spill (
      .clk_i  (clk_i              ),
      .rst_n_i(rst_n_i            ),
      .valid_i(resp_any           ),
      .ready_o(resp_spill_ready[i]),
      .data_i (resp_win           ),
      .valid_o(resp_valid_o[i]    ),
      .ready_i(resp_ready_i[i]    ),
      .data_o (resp_rdata_o[i]    )
    );
  end

endmodule : tcdm_remote_xbar

`default_nettype wire

/* rtl/mempool_group.sv */
// Group top level with the registered wake-up vector and the remote TCDM crossbar.
// NumTiles sets both the initiator and target port count.
`default_nettype none

module mempool_group #(
  parameter int unsigned NumTiles = 4,
  parameter int unsigned NumCores = 8
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  // Wake-up
  input  logic                   [NumCores-1:0]                    wake_up_i,
  output logic                   [NumCores-1:0]                    wake_up_o,
  // Initiator requests
  input  logic                   [NumTiles-1:0]                    req_valid_i,
  input  mempool_group_pkg::tcdm_addr_t [NumTiles-1:0]             req_addr_i,
  input  mempool_group_pkg::tcdm_op_e   [NumTiles-1:0]             req_op_i,
  input  mempool_group_pkg::tcdm_data_t [NumTiles-1:0]             req_wdata_i,
  input  mempool_group_pkg::tcdm_strb_t [NumTiles-1:0]             req_be_i,
  output logic                   [NumTiles-1:0]                    req_ready_o,
  // Initiator responses
  output logic                   [NumTiles-1:0]                    resp_valid_o,
  output mempool_group_pkg::tcdm_data_t [NumTiles-1:0]             resp_rdata_o,
  input  logic                   [NumTiles-1:0]                    resp_ready_i,
  // Target requests
  output logic                   [NumTiles-1:0]                    tgt_req_valid_o,
  output logic [NumTiles-1:0][mempool_group_pkg::TileOffsetBits-1:0] tgt_req_addr_o,
  output logic [NumTiles-1:0][$clog2(NumTiles)-1:0]                tgt_req_ini_o,
  output mempool_group_pkg::tcdm_op_e   [NumTiles-1:0]             tgt_req_op_o,
  output mempool_group_pkg::tcdm_data_t [NumTiles-1:0]             tgt_req_wdata_o,
  output mempool_group_pkg::tcdm_strb_t [NumTiles-1:0]             tgt_req_be_o,
  input  logic                   [NumTiles-1:0]                    tgt_req_ready_i,
  // Target responses
  input  logic                   [NumTiles-1:0]                    tgt_resp_valid_i,
  input  logic [NumTiles-1:0][$clog2(NumTiles)-1:0]                tgt_resp_ini_i,
  input  mempool_group_pkg::tcdm_data_t [NumTiles-1:0]             tgt_resp_rdata_i,
  output logic                   [NumTiles-1:0]                    tgt_resp_ready_o
);

  // One cycle wake-up delay
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wake_up_o <= '0;
    end else begin
      wake_up_o <= wake_up_i;
    end
  end

  tcdm_remote_xbar #(
    .NumTiles(NumTiles)
  ) i_remote_xbar (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .req_valid_i     (req_valid_i     ),
    .req_addr_i      (req_addr_i      ),
    .req_op_i        (req_op_i        ),
    .req_wdata_i     (req_wdata_i     ),
    .req_be_i        (req_be_i        ),
    .req_ready_o     (req_ready_o     ),
    .resp_valid_o    (resp_valid_o    ),
    .resp_rdata_o    (resp_rdata_o    ),
    .resp_ready_i    (resp_ready_i    ),
    .tgt_req_valid_o (tgt_req_valid_o ),
    .tgt_req_addr_o  (tgt_req_addr_o  ),
    .tgt_req_ini_o   (tgt_req_ini_o   ),
    .tgt_req_op_o    (tgt_req_op_o    ),
    .tgt_req_wdata_o (tgt_req_wdata_o ),
    .tgt_req_be_o    (tgt_req_be_o    ),
    .tgt_req_ready_i (tgt_req_ready_i ),
    .tgt_resp_valid_i(tgt_resp_valid_i),
    .tgt_resp_ini_i  (tgt_resp_ini_i  ),
    .tgt_resp_rdata_i(tgt_resp_rdata_i),
    .tgt_resp_ready_o(tgt_resp_ready_o)
  );

endmodule : mempool_group

`default_nettype wire

/* testbench/tb_mempool_group_tasks.svh */
// Driver, compare and directed-test tasks for the group testbench.
// Included inside the testbench module, where all DUT-side signals are in scope.
`ifndef TB_MEMPOOL_GROUP_TASKS_SVH
`define TB_MEMPOOL_GROUP_TASKS_SVH

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input tcdm_data_t exp, input tcdm_data_t got);
    if (got !== exp) begin
      fail_run($sformatf("Error %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_addr(input string name, input tcdm_addr_t exp, input tcdm_addr_t got);
    if (got !== exp) begin
      fail_run($sformatf("Error %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_ini(input string name, input logic [IdxWidth-1:0] exp,
                           input logic [IdxWidth-1:0] got);
    if (got !== exp) begin
      fail_run($sformatf("Error %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_op(input string name, input tcdm_op_e exp, input tcdm_op_e got);
    if (got !== exp) begin
      fail_run($sformatf("Error %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_be(input string name, input tcdm_strb_t exp, input tcdm_strb_t got);
    if (got !== exp) begin
      fail_run($sformatf("Error %s expected %h got %h", name, exp, got));
    end
  endtask

  // Per-port valid and ready vectors
  task automatic check_flags(input string name, input logic [NumTiles-1:0] exp,
                             input logic [NumTiles-1:0] got);
    if (got !== exp) begin
      fail_run($sformatf("Error %s expected %h got %h", name, exp, got));
    end
  endtask

  // Wake-up vectors
  task automatic check_bits(input string name, input logic [NumCores-1:0] exp,
                            input logic [NumCores-1:0] got);
    if (got !== exp) begin
      fail_run($sformatf("Error %s expected %h got %h", name, exp, got));
    end
  endtask

  // Target tile from the address bits above the tile offset
  function automatic logic [IdxWidth-1:0] tile_of(input tcdm_addr_t addr);
    return addr[TileOffsetBits +: IdxWidth];
  endfunction

  task automatic take_request(input int t);
    arrival_t got;
    arrival_t exp;
    int       word;
    got = {tgt_req_addr[t], tgt_req_ini[t], tgt_req_op[t], tgt_req_wdata[t], tgt_req_be[t]};
    if (exp_q[t * NumTiles + got.ini].size() == 0) begin
      fail_run($sformatf("Target %0d got a request from initiator %0d that was never sent there",
                         t, got.ini));
    end
    exp = exp_q[t * NumTiles + got.ini].pop_front();
    check_addr("tgt_req_addr_o", tcdm_addr_t'(exp.addr), tcdm_addr_t'(got.addr));
    check_op("tgt_req_op_o", exp.op, got.op);
    check_data("tgt_req_wdata_o", exp.wdata, got.wdata);
    check_be("tgt_req_be_o", exp.be, got.be);
    word = got.addr[TileOffsetBits-1:2];
    if (got.op == TCDM_WRITE) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (got.be[b]) begin
          tile_mem[t][word][8*b +: 8] = got.wdata[8*b +: 8];
        end
      end
    end else begin
      resp_q[t].push_back({got.ini, tile_mem[t][word]});
    end
  endtask

  task automatic take_response(input int i);
    tcdm_data_t exp;
    if (exp_resp[i].size() == 0) begin
      fail_run($sformatf("Initiator %0d got a response with no read outstanding", i));
    end
    exp = exp_resp[i].pop_front();
    check_data("resp_rdata_o", exp, resp_rdata[i]);
  endtask

  // A waiting initiator sees each competitor served at most once
  task automatic track_fairness();
    for (int k = 0; k < NumTiles; k++) begin
      if (!req_valid[k] || req_ready[k]) begin
        for (int j = 0; j < NumTiles; j++) begin
          wins[k][j] = 0;
        end
      end else begin
        for (int j = 0; j < NumTiles; j++) begin
          if (j != k && req_valid[j] && req_ready[j] &&
              tile_of(req_addr[j]) == tile_of(req_addr[k])) begin
            wins[k][j]++;
            if (wins[k][j] > 1) begin
              fail_run($sformatf("Initiator %0d was served twice while initiator %0d waited",
                                 j, k));
            end
          end
        end
      end
    end
  endtask

  task automatic issue_req(input int ini, input tcdm_addr_t addr, input tcdm_op_e op,
                           input tcdm_data_t wdata, input tcdm_strb_t be);
    arrival_t exp;
    exp = {addr[TileOffsetBits-1:0], IdxWidth'(ini), op, wdata, be};
    exp_q[tile_of(addr) * NumTiles + ini].push_back(exp);
    @(negedge clk);
    req_valid[ini] = 1'b1;
    req_addr[ini]  = addr;
    req_op[ini]    = op;
    req_wdata[ini] = wdata;
    req_be[ini]    = be;
    do begin
      @(posedge clk);
    end while (!req_ready[ini]);
    accepted_cnt[ini]++;
  endtask

  task automatic idle_ini(input int ini);
    @(negedge clk);
    req_valid[ini] = 1'b0;
  endtask

  task automatic set_ready(input int unsigned mode);
    @(posedge clk);
    ready_pat = $urandom();
    for (int t = 0; t < NumTiles; t++) begin
      ready_mode[t] = mode;
    end
  endtask

  task automatic wait_drain();
    int unsigned pending;
    do begin
      @(negedge clk);
      pending = 0;
      for (int k = 0; k < NumTiles * NumTiles; k++) begin
        pending += exp_q[k].size();
      end
      for (int i = 0; i < NumTiles; i++) begin
        pending += exp_resp[i].size();
      end
    end while (pending != 0);
  endtask

  task automatic test_reset_state();
    @(posedge clk);
    check_flags("tgt_req_valid_o", '0, tgt_req_valid);
    check_flags("resp_valid_o", '0, resp_valid);
    check_bits("wake_up_o", '0, wake_out);
  endtask

  task automatic test_write_routing();
    tcdm_addr_t addr;
    for (int i = 0; i < NumTiles; i++) begin
      for (int t = 0; t < NumTiles; t++) begin
        addr = tcdm_addr_t'($urandom());
        addr[TileOffsetBits +: IdxWidth] = IdxWidth'(t);
        issue_req(i, addr, TCDM_WRITE, $urandom(), tcdm_strb_t'($urandom()));
      end
      idle_ini(i);
    end
    wait_drain();
  endtask

  task automatic test_read_after_write();
    tcdm_addr_t addr;
    tcdm_data_t data;
    int         ini;
    set_ready(ReadyRand);
    for (int n = 0; n < RawPairs; n++) begin
      ini  = $urandom_range(NumTiles - 1);
      addr = tcdm_addr_t'($urandom());
      data = $urandom();
      issue_req(ini, addr, TCDM_WRITE, data, '1);
      exp_resp[ini].push_back(data);
      issue_req(ini, addr, TCDM_READ, '0, '1);
      idle_ini(ini);
    end
    wait_drain();
  endtask

  task automatic burst_writes(input int ini);
    tcdm_addr_t addr;
    for (int k = 0; k < BurstLen; k++) begin
      addr = '0;
      addr[TileOffsetBits +: IdxWidth] = IdxWidth'(2);
      addr[TileOffsetBits-1:0] = TileOffsetBits'((ini * BurstLen + k) * 4);
      issue_req(ini, addr, TCDM_WRITE, {8'(ini), 8'(k), 16'hbeef}, tcdm_strb_t'(k + 1));
    end
    idle_ini(ini);
  endtask

  task automatic test_burst_contention();
    set_ready(ReadyRand);
    fork
      burst_writes(0);
      burst_writes(1);
      burst_writes(2);
      burst_writes(3);
    join
    wait_drain();
  endtask

  task automatic test_backpressure();
    tcdm_addr_t  base;
    int unsigned start;
    base = 16'h0040;
    base[TileOffsetBits +: IdxWidth] = IdxWidth'(1);
    set_ready(ReadyOn);
    ready_mode[1] = ReadyLow;
    start = accepted_cnt[0];
    fork
      begin
        for (int k = 0; k < 3; k++) begin
          issue_req(0, base + tcdm_addr_t'(4 * k), TCDM_WRITE, 32'hd00d0000 + k, '1);
        end
        idle_ini(0);
      end
      begin
        while (accepted_cnt[0] < start + 2) begin
          @(negedge clk);
        end
        // Spill register full so the head entry holds still
        repeat (3) begin
          @(posedge clk);
          check_flags("req_ready_o", '0, req_ready);
          check_flags("tgt_req_valid_o", 4'b0010, tgt_req_valid);
          check_addr("tgt_req_addr_o", tcdm_addr_t'(base[TileOffsetBits-1:0]),
                     tcdm_addr_t'(tgt_req_addr[1]));
          check_ini("tgt_req_ini_o", '0, tgt_req_ini[1]);
          check_op("tgt_req_op_o", TCDM_WRITE, tgt_req_op[1]);
          check_data("tgt_req_wdata_o", 32'hd00d0000, tgt_req_wdata[1]);
        end
        ready_mode[1] = ReadyOn;
      end
    join
    wait_drain();
  endtask

  task automatic test_wake_up();
    logic [NumCores-1:0] prev;
    prev = wake_in;
    repeat (WakeVectors) begin
      @(negedge clk);
      wake_in = NumCores'($urandom());
      @(posedge clk);
      check_bits("wake_up_o", prev, wake_out);
      prev = wake_in;
    end
  endtask

`endif

/* testbench/tb_mempool_group.sv */
// Testbench for the remote TCDM group path, with one memory model per target tile.
// Runs the directed tests of the included task header after reset.
`default_nettype none

module tb_mempool_group;
  timeunit 1ns;
  timeprecision 1ps;
  import mempool_group_pkg::*;

  localparam int unsigned NumTiles    = 4;
  localparam int unsigned NumCores    = 8;
  localparam int unsigned IdxWidth    = $clog2(NumTiles);
  localparam int unsigned TileWords   = 2 ** (TileOffsetBits - 2);
  localparam time         ClkPeriod   = 4ns;
  localparam int unsigned ResetCycles = 16;
  localparam logic [31:0] Seed        = 32'h60e95352;
  localparam int unsigned RawPairs    = 8;
  localparam int unsigned BurstLen    = 6;
  localparam int unsigned WakeVectors = 16;
  localparam int unsigned NumTxn = NumTiles * NumTiles + 2 * RawPairs
                                 + NumTiles * BurstLen + 3 + WakeVectors;
  localparam int unsigned TimeoutCycles = ResetCycles + 200 * NumTxn;
  // Target ready behaviour
  localparam int unsigned ReadyOn   = 0;
  localparam int unsigned ReadyRand = 1;
  localparam int unsigned ReadyLow  = 2;

  typedef struct packed {
    logic [TileOffsetBits-1:0] addr;
    logic [IdxWidth-1:0]       ini;
    tcdm_op_e                  op;
    tcdm_data_t                wdata;
    tcdm_strb_t                be;
  } arrival_t;

  logic                                     clk;
  logic                                     rst_n;
  logic       [NumCores-1:0]                wake_in;
  logic       [NumCores-1:0]                wake_out;
  logic       [NumTiles-1:0]                req_valid;
  tcdm_addr_t [NumTiles-1:0]                req_addr;
  tcdm_op_e   [NumTiles-1:0]                req_op;
  tcdm_data_t [NumTiles-1:0]                req_wdata;
  tcdm_strb_t [NumTiles-1:0]                req_be;
  logic       [NumTiles-1:0]                req_ready;
  logic       [NumTiles-1:0]                resp_valid;
  tcdm_data_t [NumTiles-1:0]                resp_rdata;
  logic       [NumTiles-1:0]                resp_ready;
  logic       [NumTiles-1:0]                tgt_req_valid;
  logic       [NumTiles-1:0][TileOffsetBits-1:0] tgt_req_addr;
  logic       [NumTiles-1:0][IdxWidth-1:0]  tgt_req_ini;
  tcdm_op_e   [NumTiles-1:0]                tgt_req_op;
  tcdm_data_t [NumTiles-1:0]                tgt_req_wdata;
  tcdm_strb_t [NumTiles-1:0]                tgt_req_be;
  logic       [NumTiles-1:0]                tgt_req_ready;
  logic       [NumTiles-1:0]                tgt_resp_valid;
  logic       [NumTiles-1:0][IdxWidth-1:0]  tgt_resp_ini;
  tcdm_data_t [NumTiles-1:0]                tgt_resp_rdata;
  logic       [NumTiles-1:0]                tgt_resp_ready;

  // Expected traffic indexed by target * NumTiles + initiator
  arrival_t                      exp_q [NumTiles*NumTiles][$];
  tcdm_data_t                    exp_resp [NumTiles][$];
  logic [IdxWidth+DataWidth-1:0] resp_q [NumTiles][$];
  tcdm_data_t                    tile_mem [NumTiles][TileWords];
  int unsigned                   ready_mode [NumTiles];
  logic [31:0]                   ready_pat;
  int unsigned                   cycle_cnt;
  int unsigned                   accepted_cnt [NumTiles];
  int unsigned                   wins [NumTiles][NumTiles];

  `include "tb_mempool_group_tasks.svh"

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  mempool_group #(
    .NumTiles(NumTiles),
    .NumCores(NumCores)
  ) dut_i (
    .clk_i           (clk           ),
    .rst_n_i         (rst_n         ),
    .wake_up_i       (wake_in       ),
    .wake_up_o       (wake_out      ),
    .req_valid_i     (req_valid     ),
    .req_addr_i      (req_addr      ),
    .req_op_i        (req_op        ),
    .req_wdata_i     (req_wdata     ),
    .req_be_i        (req_be        ),
    .req_ready_o     (req_ready     ),
    .resp_valid_o    (resp_valid    ),
    .resp_rdata_o    (resp_rdata    ),
    .resp_ready_i    (resp_ready    ),
    .tgt_req_valid_o (tgt_req_valid ),
    .tgt_req_addr_o  (tgt_req_addr  ),
    .tgt_req_ini_o   (tgt_req_ini   ),
    .tgt_req_op_o    (tgt_req_op    ),
    .tgt_req_wdata_o (tgt_req_wdata ),
    .tgt_req_be_o    (tgt_req_be    ),
    .tgt_req_ready_i (tgt_req_ready ),
    .tgt_resp_valid_i(tgt_resp_valid),
    .tgt_resp_ini_i  (tgt_resp_ini  ),
    .tgt_resp_rdata_i(tgt_resp_rdata),
    .tgt_resp_ready_o(tgt_resp_ready)
  );

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    fail_run($sformatf("Watchdog expired after %0d cycles with traffic still pending",
                       TimeoutCycles));
  end

  // Target side stimulus on the falling edge
  always @(negedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    for (int t = 0; t < NumTiles; t++) begin
      tgt_req_ready[t] = (ready_mode[t] == ReadyOn) ||
                         ((ready_mode[t] == ReadyRand) && ready_pat[(cycle_cnt + 5 * t) % 32]);
      tgt_resp_valid[t] = (resp_q[t].size() != 0);
      if (resp_q[t].size() != 0) begin
        {tgt_resp_ini[t], tgt_resp_rdata[t]} = resp_q[t][0];
      end
    end
  end

  // Handshakes seen at the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      for (int t = 0; t < NumTiles; t++) begin
        if (tgt_resp_valid[t] && tgt_resp_ready[t]) begin
          void'(resp_q[t].pop_front());
        end
        if (tgt_req_valid[t] && tgt_req_ready[t]) begin
          take_request(t);
        end
      end
      for (int i = 0; i < NumTiles; i++) begin
        if (resp_valid[i] && resp_ready[i]) begin
          take_response(i);
        end
      end
      track_fairness();
    end
  end

  initial begin
    void'($urandom(Seed));
    rst_n          = 1'b0;
    // All ones while in reset
    wake_in        = '1;
    req_valid      = '0;
    resp_ready     = '1;
    tgt_req_ready  = '0;
    tgt_resp_valid = '0;
    ready_pat      = '0;
    cycle_cnt      = 0;
    for (int i = 0; i < NumTiles; i++) begin
      req_addr[i]       = '0;
      req_op[i]         = TCDM_READ;
      req_wdata[i]      = '0;
      req_be[i]         = '0;
      tgt_resp_ini[i]   = '0;
      tgt_resp_rdata[i] = '0;
      ready_mode[i]     = ReadyOn;
      accepted_cnt[i]   = 0;
      for (int w = 0; w < TileWords; w++) begin
        tile_mem[i][w] = 32'ha5000000 ^ {i[IdxWidth-1:0], w[TileOffsetBits-3:0], 2'b00};
      end
    end
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_write_routing();
    test_read_after_write();
    test_burst_contention();
    test_backpressure();
    test_wake_up();
    $display("STATUS: PASS");
    $finish;
  end

endmodule : tb_mempool_group

`default_nettype wire

/* mempool_group.f */
+incdir+testbench
rtl/mempool_group_pkg.sv
rtl/tcdm_spill_register.sv
rtl/tcdm_rr_arbiter.sv
rtl/tcdm_remote_xbar.sv
rtl/mempool_group.sv
testbench/tb_mempool_group.sv
